/* verilog/id_pkg.sv */
package id_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and fixed constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Link value offset added to the PC by JAL and JALR
  localparam logic [XLEN-1:0] LINK_INCR = 32'd4;

  ////////////////////////////////////////////////////////////////////////////
  // Major opcodes (RV32I subset)
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [6:0] {
    OP     = 7'h33,  // Register-register ALU
    OP_IMM = 7'h13,  // Register-immediate ALU
    LOAD   = 7'h03,
    STORE  = 7'h23,
    LUI    = 7'h37,
    AUIPC  = 7'h17,
    JAL    = 7'h6f,
    JALR   = 7'h67
  } opcode_e;

  ////////////////////////////////////////////////////////////////////////////
  // ALU operators and selects
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG  = 2'd0,
    OP_A_PC   = 2'd1,
    OP_A_ZERO = 2'd2
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG = 1'b0,
    OP_B_IMM = 1'b1
  } op_b_sel_e;

  // Register file write data source
  typedef enum logic {
    RF_WD_ALU = 1'b0,
    RF_WD_LSU = 1'b1
  } rf_wd_sel_e;

  // Load/store access size
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

endpackage

/* verilog/imm_gen.sv */
module imm_gen import id_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  input  opcode_e         imm_fmt_i,
  output logic [XLEN-1:0] imm_o
);

  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_u_type;

  // I-type, sign bit replicated from bit 31
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};

  // S-type, offset split around rd field
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  // Upper immediate, low 12 bits cleared
  assign imm_u_type = {instr_i[31:12], 12'h000};

  always_comb begin
    case (imm_fmt_i)
      OP_IMM,
      LOAD:    imm_o = imm_i_type;
      STORE:   imm_o = imm_s_type;
      LUI,
      AUIPC:   imm_o = imm_u_type;
      JAL,
      JALR:    imm_o = LINK_INCR;  // ALU forms PC + 4 for the link
      default: imm_o = '0;         // R-type and unknown opcodes
    endcase
  end

endmodule

/* verilog/instr_decoder.sv */
module instr_decoder import id_pkg::*; (
  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_i,

  output opcode_e               imm_fmt_o,

  // ALU control
  output alu_op_e               alu_op_o,
  output op_a_sel_e             op_a_sel_o,
  output op_b_sel_e             op_b_sel_o,

  // Register file
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic                  rf_ren_a_o,
  output logic                  rf_ren_b_o,
  output logic                  rf_we_o,
  output rf_wd_sel_e            rf_wd_sel_o,

  // Load/store unit
  output logic                  lsu_req_o,
  output logic                  lsu_we_o,
  output logic                  lsu_sign_ext_o,
  output lsu_type_e             lsu_type_o,

  output logic                  illegal_insn_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       funct7_ok;
  alu_op_e    arith_op;
  lsu_type_e  size_dec;

  // Raw decode before gating
  logic       illegal;
  logic       ren_a;
  logic       ren_b;
  logic       we;
  logic       req;
  logic       insn_en;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign imm_fmt_o = opcode;

  // Register fields are fixed position in every format
  assign rf_raddr_a_o = instr_i[19:15];
  assign rf_raddr_b_o = instr_i[24:20];
  assign rf_waddr_o   = instr_i[11:7];

  assign funct7_ok = (funct7 == 7'h00) || (funct7 == 7'h20);

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic operator from funct3, bit 30 picks SUB and SRA
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == OP && instr_i[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = instr_i[30] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  // Access size from funct3[1:0]
  always_comb begin
    case (funct3[1:0])
      2'b00:   size_dec = LSU_BYTE;
      2'b01:   size_dec = LSU_HALF;
      default: size_dec = LSU_WORD;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main opcode decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op_o       = ALU_ADD;
    op_a_sel_o     = OP_A_REG;
    op_b_sel_o     = OP_B_IMM;
    rf_wd_sel_o    = RF_WD_ALU;
    lsu_we_o       = 1'b0;
    lsu_type_o     = LSU_WORD;
    lsu_sign_ext_o = 1'b0;
    illegal        = 1'b0;
    ren_a          = 1'b0;
    ren_b          = 1'b0;
    we             = 1'b0;
    req            = 1'b0;

    case (opcode)
      OP: begin
        alu_op_o   = arith_op;
        op_b_sel_o = OP_B_REG;
        ren_a      = 1'b1;
        ren_b      = 1'b1;
        we         = 1'b1;
        illegal    = ~funct7_ok;
      end
      OP_IMM: begin
        alu_op_o = arith_op;
        ren_a    = 1'b1;
        we       = 1'b1;
        // Only shifts carry a funct7 field
        illegal  = (funct3[1:0] == 2'b01) && !funct7_ok;
      end
      LOAD: begin
        ren_a          = 1'b1;
        we             = 1'b1;
        req            = 1'b1;
        rf_wd_sel_o    = RF_WD_LSU;
        lsu_type_o     = size_dec;
        lsu_sign_ext_o = ~funct3[2];  // LBU and LHU zero extend
        illegal        = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      STORE: begin
        op_b_sel_o = OP_B_IMM;        // S immediate as offset
        ren_a      = 1'b1;
        ren_b      = 1'b1;
        req        = 1'b1;
        lsu_we_o   = 1'b1;
        lsu_type_o = size_dec;
        illegal    = funct3[2] || (funct3[1:0] == 2'b11);
      end
      LUI: begin
        op_a_sel_o = OP_A_ZERO;
        we         = 1'b1;
      end
      AUIPC,
      JAL: begin
        op_a_sel_o = OP_A_PC;
        we         = 1'b1;
      end
      JALR: begin
        op_a_sel_o = OP_A_PC;         // Link value only, target is outside
        ren_a      = 1'b1;
        we         = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

  // Nothing leaves decode enabled unless valid and legal
  assign insn_en = instr_valid_i & ~illegal;

  assign rf_ren_a_o     = ren_a & insn_en;
  assign rf_ren_b_o     = ren_b & insn_en;
  assign rf_we_o        = we & insn_en;
  assign lsu_req_o      = req & insn_en;
  assign illegal_insn_o = instr_valid_i & illegal;

endmodule

/* verilog/id_ex_reg.sv */
module id_ex_reg import id_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // From decode
  input  logic                  valid_i,
  input  alu_op_e               alu_op_i,
  input  op_a_sel_e             op_a_sel_i,
  input  op_b_sel_e             op_b_sel_i,
  input  logic                  rf_we_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,
  input  rf_wd_sel_e            rf_wd_sel_i,
  input  logic                  lsu_req_i,
  input  logic                  lsu_we_i,
  input  lsu_type_e             lsu_type_i,
  input  logic                  lsu_sign_ext_i,
  input  logic [XLEN-1:0]       imm_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,

  // To execute
  output logic                  ex_valid_o,
  output alu_op_e               ex_alu_op_o,
  output op_a_sel_e             ex_op_a_sel_o,
  output op_b_sel_e             ex_op_b_sel_o,
  output logic                  ex_rf_we_o,
  output logic [REG_ADDR_W-1:0] ex_rf_waddr_o,
  output rf_wd_sel_e            ex_rf_wd_sel_o,
  output logic                  ex_lsu_req_o,
  output logic                  ex_lsu_we_o,
  output lsu_type_e             ex_lsu_type_o,
  output logic                  ex_lsu_sign_ext_o,
  output logic [XLEN-1:0]       ex_imm_o,
  output logic [XLEN-1:0]       ex_pc_o,
  output logic [XLEN-1:0]       ex_rdata_a_o,
  output logic [XLEN-1:0]       ex_lsu_wdata_o   // Also rs2 data for the ALU
);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_valid_o        <= 1'b0;
      ex_alu_op_o       <= ALU_ADD;
      ex_op_a_sel_o     <= OP_A_REG;
      ex_op_b_sel_o     <= OP_B_REG;
      ex_rf_we_o        <= 1'b0;
      ex_rf_waddr_o     <= '0;
      ex_rf_wd_sel_o    <= RF_WD_ALU;
      ex_lsu_req_o      <= 1'b0;
      ex_lsu_we_o       <= 1'b0;
      ex_lsu_type_o     <= LSU_WORD;
      ex_lsu_sign_ext_o <= 1'b0;
      ex_imm_o          <= '0;
      ex_pc_o           <= '0;
      ex_rdata_a_o      <= '0;
      ex_lsu_wdata_o    <= '0;
    end else begin
      ex_valid_o        <= valid_i;
      ex_alu_op_o       <= alu_op_i;
      ex_op_a_sel_o     <= op_a_sel_i;
      ex_op_b_sel_o     <= op_b_sel_i;
      ex_rf_we_o        <= rf_we_i;   // Already gated in decode
      ex_rf_waddr_o     <= rf_waddr_i;
      ex_rf_wd_sel_o    <= rf_wd_sel_i;
      ex_lsu_req_o      <= lsu_req_i;
      ex_lsu_we_o       <= lsu_we_i;
      ex_lsu_type_o     <= lsu_type_i;
      ex_lsu_sign_ext_o <= lsu_sign_ext_i;
      ex_imm_o          <= imm_i;
      ex_pc_o           <= pc_i;
      ex_rdata_a_o      <= rf_rdata_a_i;
      ex_lsu_wdata_o    <= rf_rdata_b_i;
    end
  end

  // An empty slot must never reach execute with side effects
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !ex_valid_o |-> (!ex_rf_we_o && !ex_lsu_req_o))
    else $error("invalid slot carries rf_we or lsu_req");

endmodule

/* verilog/ex_operand_sel.sv */
module ex_operand_sel import id_pkg::*; (
  input  op_a_sel_e       op_a_sel_i,
  input  op_b_sel_e       op_b_sel_i,
  input  logic [XLEN-1:0] rdata_a_i,
  input  logic [XLEN-1:0] rdata_b_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] imm_i,
  output logic [XLEN-1:0] operand_a_o,
  output logic [XLEN-1:0] operand_b_o
);

  // Operand A mux
  always_comb begin
    case (op_a_sel_i)
      OP_A_REG:  operand_a_o = rdata_a_i;
      OP_A_PC:   operand_a_o = pc_i;      // AUIPC and link
      OP_A_ZERO: operand_a_o = '0;        // LUI
      default:   operand_a_o = '0;
    endcase
  end

  // Operand B mux
  always_comb begin
    case (op_b_sel_i)
      OP_B_REG: operand_b_o = rdata_b_i;
      default:  operand_b_o = imm_i;
    endcase
  end

  // Decode never produces the spare encoding
  always_comb begin
    assert final (op_a_sel_i inside {OP_A_REG, OP_A_PC, OP_A_ZERO})
      else $error("op_a_sel has unused encoding %0h", op_a_sel_i);
  end

endmodule

/* verilog/id_stage.sv */
module id_stage import id_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  instr_valid_i,
  input  logic [XLEN-1:0]       instr_i,
  input  logic [XLEN-1:0]       pc_i,

  // Register file read, same cycle
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic                  rf_ren_a_o,
  output logic                  rf_ren_b_o,
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,

  output logic                  illegal_insn_o,

  // Execute bundle, one cycle later
  output logic                  ex_valid_o,
  output alu_op_e               ex_alu_op_o,
  output logic [XLEN-1:0]       ex_operand_a_o,
  output logic [XLEN-1:0]       ex_operand_b_o,
  output logic                  ex_rf_we_o,
  output logic [REG_ADDR_W-1:0] ex_rf_waddr_o,
  output rf_wd_sel_e            ex_rf_wd_sel_o,
  output logic                  ex_lsu_req_o,
  output logic                  ex_lsu_we_o,
  output lsu_type_e             ex_lsu_type_o,
  output logic                  ex_lsu_sign_ext_o,
  output logic [XLEN-1:0]       ex_lsu_wdata_o,
  output logic [XLEN-1:0]       ex_pc_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Decode side wires
  ////////////////////////////////////////////////////////////////////////////

  opcode_e               imm_fmt;
  alu_op_e               alu_op;
  op_a_sel_e             op_a_sel;
  op_b_sel_e             op_b_sel;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic                  rf_we;
  rf_wd_sel_e            rf_wd_sel;
  logic                  lsu_req;
  logic                  lsu_we;
  logic                  lsu_sign_ext;
  lsu_type_e             lsu_type;
  logic [XLEN-1:0]       imm;

  // Registered selects and data
  op_a_sel_e             ex_op_a_sel;
  op_b_sel_e             ex_op_b_sel;
  logic [XLEN-1:0]       ex_imm;
  logic [XLEN-1:0]       ex_rdata_a;

  instr_decoder u_instr_decoder (
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .imm_fmt_o      (imm_fmt),
    .alu_op_o       (alu_op),
    .op_a_sel_o     (op_a_sel),
    .op_b_sel_o     (op_b_sel),
    .rf_raddr_a_o   (rf_raddr_a_o),
    .rf_raddr_b_o   (rf_raddr_b_o),
    .rf_waddr_o     (rf_waddr),
    .rf_ren_a_o     (rf_ren_a_o),
    .rf_ren_b_o     (rf_ren_b_o),
    .rf_we_o        (rf_we),
    .rf_wd_sel_o    (rf_wd_sel),
    .lsu_req_o      (lsu_req),
    .lsu_we_o       (lsu_we),
    .lsu_sign_ext_o (lsu_sign_ext),
    .lsu_type_o     (lsu_type),
    .illegal_insn_o (illegal_insn_o)
  );

  imm_gen u_imm_gen (
    .instr_i   (instr_i),
    .imm_fmt_i (imm_fmt),
    .imm_o     (imm)
  );

  id_ex_reg u_id_ex_reg (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .valid_i           (instr_valid_i),
    .alu_op_i          (alu_op),
    .op_a_sel_i        (op_a_sel),
    .op_b_sel_i        (op_b_sel),
    .rf_we_i           (rf_we),
    .rf_waddr_i        (rf_waddr),
    .rf_wd_sel_i       (rf_wd_sel),
    .lsu_req_i         (lsu_req),
    .lsu_we_i          (lsu_we),
    .lsu_type_i        (lsu_type),
    .lsu_sign_ext_i    (lsu_sign_ext),
    .imm_i             (imm),
    .pc_i              (pc_i),
    .rf_rdata_a_i      (rf_rdata_a_i),
    .rf_rdata_b_i      (rf_rdata_b_i),
    .ex_valid_o        (ex_valid_o),
    .ex_alu_op_o       (ex_alu_op_o),
    .ex_op_a_sel_o     (ex_op_a_sel),
    .ex_op_b_sel_o     (ex_op_b_sel),
    .ex_rf_we_o        (ex_rf_we_o),
    .ex_rf_waddr_o     (ex_rf_waddr_o),
    .ex_rf_wd_sel_o    (ex_rf_wd_sel_o),
    .ex_lsu_req_o      (ex_lsu_req_o),
    .ex_lsu_we_o       (ex_lsu_we_o),
    .ex_lsu_type_o     (ex_lsu_type_o),
    .ex_lsu_sign_ext_o (ex_lsu_sign_ext_o),
    .ex_imm_o          (ex_imm),
    .ex_pc_o           (ex_pc_o),
    .ex_rdata_a_o      (ex_rdata_a),
    .ex_lsu_wdata_o    (ex_lsu_wdata_o)
  );

  ex_operand_sel u_ex_operand_sel (
    .op_a_sel_i  (ex_op_a_sel),
    .op_b_sel_i  (ex_op_b_sel),
    .rdata_a_i   (ex_rdata_a),
    .rdata_b_i   (ex_lsu_wdata_o),  // Registered rs2 data
    .pc_i        (ex_pc_o),
    .imm_i       (ex_imm),
    .operand_a_o (ex_operand_a_o),
    .operand_b_o (ex_operand_b_o)
  );

endmodule

/* dv/tb_id_stage.sv */
module tb_id_stage import id_pkg::*; ();

  logic                  clk_i;
  logic                  rst_ni;
  logic                  instr_valid_i;
  logic [XLEN-1:0]       instr_i;
  logic [XLEN-1:0]       pc_i;
  logic [XLEN-1:0]       rf_rdata_a_i;
  logic [XLEN-1:0]       rf_rdata_b_i;
  logic [REG_ADDR_W-1:0] rf_raddr_a_o;
  logic [REG_ADDR_W-1:0] rf_raddr_b_o;
  logic                  rf_ren_a_o;
  logic                  rf_ren_b_o;
  logic                  illegal_insn_o;
  logic                  ex_valid_o;
  alu_op_e               ex_alu_op_o;
  logic [XLEN-1:0]       ex_operand_a_o;
  logic [XLEN-1:0]       ex_operand_b_o;
  logic                  ex_rf_we_o;
  logic [REG_ADDR_W-1:0] ex_rf_waddr_o;
  rf_wd_sel_e            ex_rf_wd_sel_o;
  logic                  ex_lsu_req_o;
  logic                  ex_lsu_we_o;
  lsu_type_e             ex_lsu_type_o;
  logic                  ex_lsu_sign_ext_o;
  logic [XLEN-1:0]       ex_lsu_wdata_o;
  logic [XLEN-1:0]       ex_pc_o;

  // Stimulus as it stood at the last rising edge
  logic [XLEN-1:0]       prev_instr;
  logic [XLEN-1:0]       prev_pc;
  logic                  prev_valid = 1'b0;
  logic                  prev_ok;
  logic                  prev_mem;
  logic                  prev_load;

  integer seed;
  int     errors = 0;
  int     sent   = 0;
  int     seen   = 0;

  id_stage u_id_stage (.*);

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Each byte holds the register address
  function automatic logic [XLEN-1:0] rf_value(logic [REG_ADDR_W-1:0] addr);
    return {4{3'b000, addr}};
  endfunction

  function automatic logic is_legal(logic [XLEN-1:0] ins);
    logic [2:0] f3;
    logic       f7_ok;
    f3    = ins[14:12];
    f7_ok = (ins[31:25] == 7'h00) || (ins[31:25] == 7'h20);
    case (ins[6:0])
      OP:                      return f7_ok;
      OP_IMM:                  return f7_ok || (f3 != 3'd1 && f3 != 3'd5);  // Shifts only
      LOAD:                    return f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
      STORE:                   return f3 inside {3'd0, 3'd1, 3'd2};
      LUI, AUIPC, JAL, JALR:   return 1'b1;
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic logic reads_rs1(logic [XLEN-1:0] ins);
    return ins[6:0] inside {OP, OP_IMM, LOAD, STORE, JALR};
  endfunction

  function automatic alu_op_e exp_alu_op(logic [XLEN-1:0] ins);
    if (!(ins[6:0] inside {OP, OP_IMM}))
      return ALU_ADD;  // Address and link sums
    case (ins[14:12])
      3'd0:    return (ins[30] && ins[6:0] == OP) ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return ins[30] ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] exp_op_a(logic [XLEN-1:0] ins, logic [XLEN-1:0] pc);
    case (ins[6:0])
      LUI:              return '0;
      AUIPC, JAL, JALR: return pc;
      default:          return rf_value(ins[19:15]);
    endcase
  endfunction

  function automatic logic [XLEN-1:0] exp_op_b(logic [XLEN-1:0] ins);
    case (ins[6:0])
      OP:           return rf_value(ins[24:20]);
      OP_IMM, LOAD: return 32'($signed(ins[31:20]));
      STORE:        return 32'($signed({ins[31:25], ins[11:7]}));
      LUI, AUIPC:   return {ins[31:12], 12'h000};
      default:      return 32'd4;  // Jumps link to pc + 4
    endcase
  endfunction

  function automatic lsu_type_e exp_size(logic [XLEN-1:0] ins);
    case (ins[13:12])
      2'd0:    return LSU_BYTE;
      2'd1:    return LSU_HALF;
      default: return LSU_WORD;
    endcase
  endfunction

  assign rf_rdata_a_i = rf_value(rf_raddr_a_o);
  assign rf_rdata_b_i = rf_value(rf_raddr_b_o);

  assign prev_ok   = prev_valid && is_legal(prev_instr);
  assign prev_mem  = prev_ok && (prev_instr[6:0] inside {LOAD, STORE});
  assign prev_load = prev_ok && (prev_instr[6:0] == LOAD);

  always @(posedge clk_i) begin
    prev_instr <= instr_i;
    prev_pc    <= pc_i;
    prev_valid <= instr_valid_i;
  end

  always @(negedge clk_i) begin
    if (rst_ni && ex_valid_o)
      seen++;
  end

  task automatic report_mismatch(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
    errors++;
    $display("[ERROR] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks, sampled at the falling edge
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(negedge clk_i) rst_ni ||
    {ex_alu_op_o, ex_valid_o, ex_rf_we_o, ex_lsu_req_o} == {ALU_ADD, 3'b000})
    else report_mismatch("ex_alu_op_o,ex_valid_o,ex_rf_we_o,ex_lsu_req_o",
      32'({ex_alu_op_o, ex_valid_o, ex_rf_we_o, ex_lsu_req_o}), 32'({ALU_ADD, 3'b000}));
  assert property (@(negedge clk_i) rst_ni ||
    (ex_operand_a_o | ex_operand_b_o | ex_pc_o | ex_lsu_wdata_o) == '0)
    else report_mismatch("ex data outputs in reset",
      ex_operand_a_o | ex_operand_b_o | ex_pc_o | ex_lsu_wdata_o, '0);

  // Same cycle as the instruction
  assert property (@(negedge clk_i) disable iff (!rst_ni)
    {rf_raddr_a_o, rf_raddr_b_o} == {instr_i[19:15], instr_i[24:20]})
    else report_mismatch("rf_raddr_a_o,rf_raddr_b_o", 32'({rf_raddr_a_o, rf_raddr_b_o}),
      32'({instr_i[19:15], instr_i[24:20]}));
  assert property (@(negedge clk_i) disable iff (!rst_ni)
    rf_ren_a_o == (instr_valid_i && is_legal(instr_i) && reads_rs1(instr_i)))
    else report_mismatch("rf_ren_a_o", 32'(rf_ren_a_o),
      32'(instr_valid_i && is_legal(instr_i) && reads_rs1(instr_i)));
  assert property (@(negedge clk_i) disable iff (!rst_ni)
    rf_ren_b_o == (instr_valid_i && is_legal(instr_i) && instr_i[6:0] inside {OP, STORE}))
    else report_mismatch("rf_ren_b_o", 32'(rf_ren_b_o),
      32'(instr_valid_i && is_legal(instr_i) && instr_i[6:0] inside {OP, STORE}));
  assert property (@(negedge clk_i) disable iff (!rst_ni)
    illegal_insn_o == (instr_valid_i && !is_legal(instr_i)))
    else report_mismatch("illegal_insn_o", 32'(illegal_insn_o),
      32'(instr_valid_i && !is_legal(instr_i)));

  // One cycle later
  assert property (@(negedge clk_i) disable iff (!rst_ni) ex_valid_o == prev_valid)
    else report_mismatch("ex_valid_o", 32'(ex_valid_o), 32'(prev_valid));
  assert property (@(negedge clk_i) disable iff (!rst_ni)
    ex_rf_we_o == (prev_ok && prev_instr[6:0] != STORE))
    else report_mismatch("ex_rf_we_o", 32'(ex_rf_we_o), 32'(prev_ok && prev_instr[6:0] != STORE));
  assert property (@(negedge clk_i) disable iff (!rst_ni) ex_lsu_req_o == prev_mem)
    else report_mismatch("ex_lsu_req_o", 32'(ex_lsu_req_o), 32'(prev_mem));
  assert property (@(negedge clk_i) disable iff (!rst_ni)
    !prev_ok || ex_alu_op_o == exp_alu_op(prev_instr))
    else report_mismatch("ex_alu_op_o", 32'(ex_alu_op_o), 32'(exp_alu_op(prev_instr)));
  assert property (@(negedge clk_i) disable iff (!rst_ni)
    !prev_ok || ex_operand_a_o == exp_op_a(prev_instr, prev_pc))
    else report_mismatch("ex_operand_a_o", ex_operand_a_o, exp_op_a(prev_instr, prev_pc));
  assert property (@(negedge clk_i) disable iff (!rst_ni)
    !prev_ok || ex_operand_b_o == exp_op_b(prev_instr))
    else report_mismatch("ex_operand_b_o", ex_operand_b_o, exp_op_b(prev_instr));
  assert property (@(negedge clk_i) disable iff (!rst_ni)
    !prev_ok || ex_rf_waddr_o == prev_instr[11:7])
    else report_mismatch("ex_rf_waddr_o", 32'(ex_rf_waddr_o), 32'(prev_instr[11:7]));
  assert property (@(negedge clk_i) disable iff (!rst_ni)
    !prev_ok || ex_rf_wd_sel_o == (prev_load ? RF_WD_LSU : RF_WD_ALU))
    else report_mismatch("ex_rf_wd_sel_o", 32'(ex_rf_wd_sel_o), 32'(prev_load));
  assert property (@(negedge clk_i) disable iff (!rst_ni)
    !prev_mem || {ex_lsu_we_o, ex_lsu_type_o} == {!prev_load, exp_size(prev_instr)})
    else report_mismatch("ex_lsu_we_o,ex_lsu_type_o", 32'({ex_lsu_we_o, ex_lsu_type_o}),
      32'({!prev_load, exp_size(prev_instr)}));
  assert property (@(negedge clk_i) disable iff (!rst_ni)
    !prev_load || ex_lsu_sign_ext_o == !prev_instr[14])
    else report_mismatch("ex_lsu_sign_ext_o", 32'(ex_lsu_sign_ext_o), 32'(!prev_instr[14]));
  assert property (@(negedge clk_i) disable iff (!rst_ni)
    !prev_ok || ex_lsu_wdata_o == rf_value(prev_instr[24:20]))
    else report_mismatch("ex_lsu_wdata_o", ex_lsu_wdata_o, rf_value(prev_instr[24:20]));
  assert property (@(negedge clk_i) disable iff (!rst_ni) !prev_valid || ex_pc_o == prev_pc)
    else report_mismatch("ex_pc_o", ex_pc_o, prev_pc);

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_random;
    logic [XLEN-1:0] ins;
    logic [XLEN-1:0] r;
    int unsigned     kind;
    ins  = $random(seed);
    r    = $random(seed);
    kind = $unsigned($random(seed)) % 10;
    case (kind)
      0: begin
        ins[6:0]   = OP;
        ins[31:25] = {1'b0, ins[30], 5'b00000};
      end
      1: ins[6:0] = OP_IMM;  // Shift fields stay random
      2, 3: begin
        ins[6:0] = (kind == 2) ? LOAD : STORE;
        ins[14]  = (kind == 2) && ins[14] && !ins[13];
        if (ins[13:12] == 2'b11)
          ins[12] = 1'b0;
      end
      4: ins[6:0] = LUI;
      5: ins[6:0] = AUIPC;
      6: ins[6:0] = JAL;
      7: ins[6:0] = JALR;
      8: ins[6:0] = r[1] ? (r[0] ? OP : LOAD) : (r[0] ? STORE : OP_IMM);  // Unchecked fields
      default: ;  // Raw word, mostly bad opcodes
    endcase
    instr_i       = ins;
    instr_valid_i = (r[30:28] != 3'd0);
    pc_i          = {r[27:2], 2'b00} ^ 32'h0001_0000;
    if (instr_valid_i)
      sent++;
  endtask

  // Every valid instruction has to show up at execute
  task automatic wait_drained;
    int cycles;
    cycles = 0;
    while (seen != sent && cycles < 20) begin
      @(posedge clk_i);
      cycles++;
    end
    if (seen != sent) begin
      errors++;
      $display("Timeout: only %0d of %0d valid instructions reached execute", seen, sent);
    end
  endtask

  initial begin
    seed          = 26181;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    repeat (5) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    repeat (400) begin
      @(posedge clk_i);
      #2 drive_random();  // Small hold after the edge
    end
    @(posedge clk_i);
    #2 instr_valid_i = 1'b0;
    wait_drained();
    $display("errors: %0d, valid instructions: %0d, seen at execute: %0d", errors, sent, seen);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* build.f */
verilog/id_pkg.sv
verilog/imm_gen.sv
verilog/instr_decoder.sv
verilog/id_ex_reg.sv
verilog/ex_operand_sel.sv
verilog/id_stage.sv
dv/tb_id_stage.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module tb_id_stage -o tb_id_stage
	out="$$(./obj_dir/tb_id_stage)"; echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir
